// ==== sources.f ====
+incdir+rtl
rtl/tok_pkg.sv
rtl/tok_sram.sv
rtl/grouper.sv
rtl/encoder.sv
rtl/tokenizer_top.sv
verif/tb_tokenizer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tokenizer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_tokenizer -f sources.f \
    && ./obj_dir/Vtb_tokenizer > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0

// ==== verif/tb_tokenizer.sv ====
`timescale 1ns/1ps
`include "tok_defines.svh"

module tb_tokenizer;

    localparam int DEPTH          = 2 ** `ADDR_WIDTH;
    localparam int SLOTS          = `NUM_ENTRIES * `TOKEN_LEN;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [7:0] SPACE  = 8'd32;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   load_we;
    logic [1:0]             load_sel;
    logic [`ADDR_WIDTH-1:0] load_addr;
    logic [7:0]             load_data;
    logic [`ADDR_WIDTH-1:0] rd_addr;
    logic [`CODE_WIDTH-1:0] rd_code;
    logic [`ADDR_WIDTH-1:0] code_count;
    logic                   done;

    // Host copies of the three loadable RAMs.
    logic [7:0]             text_img  [DEPTH];
    logic [7:0]             vocab_img [SLOTS];
    logic [`CODE_WIDTH-1:0] code_img  [`NUM_ENTRIES];

    logic [7:0]             work_img  [$];
    logic [`CODE_WIDTH-1:0] exp_codes [$];
    logic [`CODE_WIDTH-1:0] got_codes [$];

    logic [15:0] lfsr_state;
    int          mismatches;
    int          failures;
    logic        timed_out;

    tokenizer_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load_we    (load_we),
        .load_sel   (load_sel),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_addr    (rd_addr),
        .rd_code    (rd_code),
        .code_count (code_count),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Stimulus helpers.
    // ------------------------------------------------------------

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = {1'b0, s[15:1]};
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic clear_vocab();
        for (int i = 0; i < SLOTS; i++) begin
            vocab_img[i] = 8'd0;
        end
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            code_img[i] = '0;
        end
    endtask

    task automatic set_entry(input int idx, input string tok, input logic [`CODE_WIDTH-1:0] code);
        for (int i = 0; i < `TOKEN_LEN; i++) begin
            vocab_img[idx * `TOKEN_LEN + i] = (i < tok.len()) ? tok[i] : 8'd0;
        end
        code_img[idx] = code;
    endtask

    task automatic set_text(input string txt);
        for (int i = 0; i < DEPTH; i++) begin
            text_img[i] = (i < txt.len()) ? txt[i] : 8'd0;
        end
    endtask

    task automatic write_word(input logic [1:0] sel, input int addr, input logic [7:0] data);
        @(posedge clk);
        load_we   <= 1'b1;
        load_sel  <= sel;
        load_addr <= addr[`ADDR_WIDTH-1:0];
        load_data <= data;
    endtask

    task automatic load_memories();
        for (int i = 0; i < DEPTH; i++) begin
            write_word(2'd0, i, text_img[i]);
        end
        for (int i = 0; i < SLOTS; i++) begin
            write_word(2'd1, i, vocab_img[i]);
        end
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            write_word(2'd2, i, code_img[i]);
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Reference model.
    // ------------------------------------------------------------

    function automatic int token_length(input int e);
        int n;
        n = 0;
        while (n < `TOKEN_LEN && vocab_img[e * `TOKEN_LEN + n] != 8'd0) begin
            n++;
        end
        return n;
    endfunction

    function automatic bit token_fits(input int e, input int pos, input int len);
        for (int i = 0; i < len; i++) begin
            if (pos + i >= work_img.size()) begin
                return 1'b0;
            end
            if (work_img[pos + i] != vocab_img[e * `TOKEN_LEN + i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Space grouping first, then the lowest entry that fits at each position.
    task automatic model_tokenize();
        logic prev_space;
        int   pos;
        int   hit;
        work_img.delete();
        exp_codes.delete();
        prev_space = 1'b0;
        for (int i = 0; i < DEPTH - 1 && text_img[i] != 8'd0; i++) begin
            if (!(text_img[i] == SPACE && (prev_space || work_img.size() == 0))) begin
                work_img.push_back(text_img[i]);
                prev_space = (text_img[i] == SPACE);
            end
        end
        work_img.push_back(8'd0);
        pos = 0;
        while (work_img[pos] != 8'd0) begin
            hit = -1;
            for (int e = 0; e < `NUM_ENTRIES && hit < 0; e++) begin
                if (token_length(e) > 0 && token_fits(e, pos, token_length(e))) begin
                    hit = e;
                end
            end
            if (hit >= 0) begin
                exp_codes.push_back(code_img[hit]);
                pos += token_length(hit);
            end else begin
                exp_codes.push_back(`UNK_CODE);
                pos += 1;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Checking and sequencing.
    // ------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else begin
            failures++;
            timed_out = 1'b1;
            $display("Timeout at %0t: done did not rise within %0d cycles", $time, TIMEOUT_CYCLES);
        end
    endtask

    // Load, encode once, then read back every code and compare with the model.
    task automatic encode_and_compare(input string label);
        if (timed_out) begin
            return;
        end
        load_memories();
        model_tokenize();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value({label, " done after start"}, 32'(done), 0);
        check_value({label, " code_count after start"}, 32'(code_count), 0);
        wait_done();
        if (timed_out) begin
            return;
        end
        check_value({label, " code_count"}, 32'(code_count), exp_codes.size());
        got_codes.delete();
        for (int i = 0; i < exp_codes.size(); i++) begin
            @(posedge clk);
            rd_addr <= i[`ADDR_WIDTH-1:0];
            @(posedge clk);
            @(negedge clk);
            got_codes.push_back(rd_code);
            check_value($sformatf("%s rd_code[%0d]", label, i), 32'(rd_code), 32'(exp_codes[i]));
        end
    endtask

    task automatic test_single_entries();
        clear_vocab();
        set_entry(0, "ab", 8'h10);
        set_entry(1, " ", 8'h20);
        set_text("ab ab");
        encode_and_compare("single entries");
        check_value("single entries code_count", 32'(code_count), 3);
    endtask

    task automatic test_first_match();
        clear_vocab();
        set_entry(0, "a", 8'h05);
        set_entry(1, "ab", 8'h06);
        set_text("ab");
        encode_and_compare("first match without b");
        check_value("first match rd_code[0]", 32'(got_codes[0]), 32'h05);
        check_value("first match rd_code[1]", 32'(got_codes[1]), 32'(`UNK_CODE));
        set_entry(2, "b", 8'h07);
        encode_and_compare("first match with b");
    endtask

    task automatic test_unknown_chars();
        clear_vocab();
        set_entry(0, "a", 8'h01);
        set_entry(1, "bc", 8'h02);
        set_text("xaqbcz");
        encode_and_compare("unknown chars");
    endtask

    task automatic test_space_grouping();
        logic [`CODE_WIDTH-1:0] saved [$];
        bit same;
        clear_vocab();
        set_entry(0, " ", 8'h03);
        set_entry(1, "ab", 8'h04);
        set_entry(2, "a", 8'h01);
        set_entry(3, "b", 8'h02);
        set_text("   a  b   ab  ");
        encode_and_compare("grouping with runs");
        saved = got_codes;
        set_text("a b ab ");
        encode_and_compare("grouping single spaces");
        same = (saved.size() == got_codes.size());
        for (int i = 0; i < saved.size() && same; i++) begin
            same = (saved[i] == got_codes[i]);
        end
        assert (same) else begin
            failures++;
            $display("Grouped text and single-spaced text gave different code sequences");
        end
    endtask

    task automatic test_restart();
        clear_vocab();
        set_entry(0, "abc", 8'h09);
        set_entry(1, "c", 8'h08);
        set_entry(2, "a", 8'h07);
        set_entry(3, "b", 8'h06);
        set_text("abcab");
        encode_and_compare("restart first run");
        set_text("cab c");
        encode_and_compare("restart second run");
    endtask

    task automatic test_random_texts();
        string alphabet = "abc ";
        int    len;
        int    pick;
        clear_vocab();
        set_entry(0, "abc", 8'h16);
        set_entry(1, "ab", 8'h11);
        set_entry(2, "ca", 8'h15);
        set_entry(3, "a", 8'h12);
        set_entry(4, "b", 8'h13);
        set_entry(5, " ", 8'h14);
        for (int t = 0; t < 10; t++) begin
            set_text("");
            take_bits(5, len);
            len = len + 8;
            for (int i = 0; i < len; i++) begin
                take_bits(2, pick);
                text_img[i] = alphabet[pick];
            end
            encode_and_compare($sformatf("random text %0d", t));
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        load_we    = 1'b0;
        load_sel   = 2'd0;
        load_addr  = '0;
        load_data  = '0;
        rd_addr    = '0;
        lfsr_state = 16'd45452;
        mismatches = 0;
        failures   = 0;
        timed_out  = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("done after reset", 32'(done), 0);
        check_value("code_count after reset", 32'(code_count), 0);

        test_single_entries();
        test_first_match();
        test_unknown_chars();
        test_space_grouping();
        test_restart();
        test_random_texts();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/tokenizer_top.sv ====
`timescale 1ns/1ps

module tokenizer_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           load_we,
    input  logic [1:0]     load_sel,
    input  tok_pkg::addr_t load_addr,
    input  tok_pkg::char_t load_data,
    input  tok_pkg::addr_t rd_addr,
    output tok_pkg::code_t rd_code,
    output tok_pkg::addr_t code_count,
    output logic           done
);

    logic           grp_start;
    logic           grp_busy;
    logic           grp_done;
    tok_pkg::addr_t grp_text_addr;
    logic           grp_work_we;
    tok_pkg::addr_t grp_work_addr;
    tok_pkg::char_t grp_work_din;

    logic           enc_busy;
    logic           enc_done;
    tok_pkg::addr_t enc_count;
    tok_pkg::addr_t enc_work_addr;
    tok_pkg::addr_t enc_vocab_addr;
    tok_pkg::addr_t enc_code_addr;
    logic           enc_out_we;
    tok_pkg::addr_t enc_out_addr;
    tok_pkg::code_t enc_out_din;

    tok_pkg::char_t text_dout;
    tok_pkg::char_t vocab_dout;
    tok_pkg::char_t work_dout;
    tok_pkg::code_t code_dout;

    // Start is only taken in idle or done.
    assign grp_start = start && !grp_busy && !enc_busy;

    // Done and count read as cleared from the cycle after start.
    assign done       = enc_done && !grp_busy;
    assign code_count = grp_busy ? '0 : enc_count;

    // ------------------------------------------------------------
    // Memories. Port owner follows the busy levels, else the host.
    // ------------------------------------------------------------

    tok_sram #(.word_t(tok_pkg::char_t)) text_ram (
        .clk  (clk),
        .we   (load_we && (load_sel == 2'd0)),
        .addr (grp_busy ? grp_text_addr : load_addr),
        .din  (load_data),
        .dout (text_dout)
    );

    tok_sram #(.word_t(tok_pkg::char_t)) vocab_ram (
        .clk  (clk),
        .we   (load_we && (load_sel == 2'd1)),
        .addr (enc_busy ? enc_vocab_addr : load_addr),
        .din  (load_data),
        .dout (vocab_dout)
    );

    tok_sram #(.word_t(tok_pkg::code_t)) code_ram (
        .clk  (clk),
        .we   (load_we && (load_sel == 2'd2)),
        .addr (enc_busy ? enc_code_addr : load_addr),
        .din  (tok_pkg::code_t'(load_data)),
        .dout (code_dout)
    );

    tok_sram #(.word_t(tok_pkg::char_t)) work_ram (
        .clk  (clk),
        .we   (grp_busy && grp_work_we),
        .addr (grp_busy ? grp_work_addr : enc_work_addr),
        .din  (grp_work_din),
        .dout (work_dout)
    );

    tok_sram #(.word_t(tok_pkg::code_t)) out_ram (
        .clk  (clk),
        .we   (enc_busy && enc_out_we),
        .addr (enc_busy ? enc_out_addr : rd_addr),
        .din  (enc_out_din),
        .dout (rd_code)
    );

    // ------------------------------------------------------------
    // Grouper and encoder.
    // ------------------------------------------------------------

    grouper u_grouper (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (grp_start),
        .text_addr  (grp_text_addr),
        .text_data  (text_dout),
        .work_we    (grp_work_we),
        .work_addr  (grp_work_addr),
        .work_din   (grp_work_din),
        .busy       (grp_busy),
        .group_done (grp_done)
    );

    encoder u_encoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .group_done (grp_done),
        .busy       (enc_busy),
        .work_addr  (enc_work_addr),
        .work_data  (work_dout),
        .vocab_addr (enc_vocab_addr),
        .vocab_data (vocab_dout),
        .code_addr  (enc_code_addr),
        .code_data  (code_dout),
        .out_we     (enc_out_we),
        .out_addr   (enc_out_addr),
        .out_din    (enc_out_din),
        .code_count (enc_count),
        .done       (enc_done)
    );

    // The work RAM port mux relies on the two phases never overlapping.
    a_phase_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(grp_busy && enc_busy)
    );

endmodule

// ==== rtl/encoder.sv ====
`timescale 1ns/1ps
`include "tok_defines.svh"

module encoder (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           group_done,
    output logic           busy,
    output tok_pkg::addr_t work_addr,
    input  tok_pkg::char_t work_data,
    output tok_pkg::addr_t vocab_addr,
    input  tok_pkg::char_t vocab_data,
    output tok_pkg::addr_t code_addr,
    input  tok_pkg::code_t code_data,
    output logic           out_we,
    output tok_pkg::addr_t out_addr,
    output tok_pkg::code_t out_din,
    output tok_pkg::addr_t code_count,
    output logic           done
);

    localparam int ENTRY_W = $clog2(`NUM_ENTRIES + 1);
    localparam int OFF_W   = $clog2(`TOKEN_LEN + 1);

    // One past the last entry marks an unknown character.
    localparam logic [ENTRY_W-1:0] UNK_ENTRY = ENTRY_W'(`NUM_ENTRIES);
    localparam logic [OFF_W-1:0]   LAST_OFF  = OFF_W'(`TOKEN_LEN - 1);

    tok_pkg::enc_state_t state;
    tok_pkg::addr_t      pos;
    logic [ENTRY_W-1:0]  entry;
    logic [OFF_W-1:0]    off;
    tok_pkg::addr_t      match_len;

    logic chars_equal;
    logic slot_end;
    logic text_end;

    // ------------------------------------------------------------
    // RAM addressing. Work and vocab step together by offset.
    // ------------------------------------------------------------

    assign work_addr  = pos + tok_pkg::addr_t'(off);
    assign vocab_addr = tok_pkg::addr_t'(entry * `TOKEN_LEN) + tok_pkg::addr_t'(off);
    assign code_addr  = tok_pkg::addr_t'(entry);

    assign chars_equal = (vocab_data == work_data);

    // A pad zero after at least one char ends the slot. Empty slots never match.
    assign slot_end = (vocab_data == tok_pkg::CHAR_NUL) && (off != '0);
    assign text_end = (off == '0) && (work_data == tok_pkg::CHAR_NUL);

    assign out_we  = (state == tok_pkg::E_EMIT);
    assign out_addr = code_count;
    assign out_din = (entry == UNK_ENTRY) ? `UNK_CODE : code_data;

    assign busy = (state != tok_pkg::E_IDLE) && (state != tok_pkg::E_DONE);

    // ------------------------------------------------------------
    // Matcher FSM.
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= tok_pkg::E_IDLE;
            pos        <= '0;
            entry      <= '0;
            off        <= '0;
            match_len  <= '0;
            code_count <= '0;
            done       <= 1'b0;
        end else begin
            case (state)
                tok_pkg::E_IDLE, tok_pkg::E_DONE: begin
                    if (group_done) begin
                        pos        <= '0;
                        entry      <= '0;
                        off        <= '0;
                        code_count <= '0;
                        done       <= 1'b0;
                        state      <= tok_pkg::E_WAIT;
                    end
                end
                // Handover cycle, the grouper has just released the work RAM.
                tok_pkg::E_WAIT: begin
                    state <= tok_pkg::E_FETCH;
                end
                tok_pkg::E_FETCH: begin
                    state <= tok_pkg::E_CMP;
                end
                tok_pkg::E_CMP: begin
                    if (text_end) begin
                        done  <= 1'b1;
                        state <= tok_pkg::E_DONE;
                    end else if (slot_end) begin
                        match_len <= tok_pkg::addr_t'(off);
                        state     <= tok_pkg::E_EMIT;
                    end else if (!chars_equal) begin
                        state <= tok_pkg::E_NEXT;
                    end else if (off == LAST_OFF) begin
                        // Full slot matched.
                        match_len <= tok_pkg::addr_t'(`TOKEN_LEN);
                        state     <= tok_pkg::E_EMIT;
                    end else begin
                        off   <= off + 1'b1;
                        state <= tok_pkg::E_FETCH;
                    end
                end
                // Rewind to the current position and try the next entry.
                tok_pkg::E_NEXT: begin
                    off <= '0;
                    if (entry == UNK_ENTRY - 1'b1) begin
                        entry     <= UNK_ENTRY;
                        match_len <= tok_pkg::addr_t'(1);
                        state     <= tok_pkg::E_EMIT;
                    end else begin
                        entry <= entry + 1'b1;
                        state <= tok_pkg::E_FETCH;
                    end
                end
                // Code RAM output is stable here, entry has not moved for two cycles.
                tok_pkg::E_EMIT: begin
                    code_count <= code_count + 1'b1;
                    state      <= tok_pkg::E_ADV;
                end
                tok_pkg::E_ADV: begin
                    pos   <= pos + match_len;
                    entry <= '0;
                    off   <= '0;
                    state <= tok_pkg::E_FETCH;
                end
                default: begin
                    state <= tok_pkg::E_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------

    // The terminator bounds the text, so the count never wraps.
    a_count_room: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_we |-> (code_count != '1)
    );

    a_done_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(done && busy)
    );

endmodule

// ==== rtl/grouper.sv ====
`timescale 1ns/1ps

module grouper (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    output tok_pkg::addr_t text_addr,
    input  tok_pkg::char_t text_data,
    output logic           work_we,
    output tok_pkg::addr_t work_addr,
    output tok_pkg::char_t work_din,
    output logic           busy,
    output logic           group_done
);

    tok_pkg::grp_state_t state;
    tok_pkg::addr_t      wr_ptr;
    logic                prev_space;
    logic                wrote_any;

    logic is_space;
    logic is_end;
    logic skip;
    logic copy;

    // ------------------------------------------------------------
    // Character classification on the text RAM output.
    // ------------------------------------------------------------

    assign is_space = (text_data == tok_pkg::CHAR_SPACE);

    // The last address is never copied, it is replaced by the terminator.
    assign is_end = (text_data == tok_pkg::CHAR_NUL) || (text_addr == '1);

    // Leading spaces and repeated spaces are dropped.
    assign skip = is_space && (prev_space || !wrote_any);

    assign copy = (state == tok_pkg::G_COPY) && !is_end && !skip;

    assign work_we    = copy || (state == tok_pkg::G_TERM);
    assign work_addr  = wr_ptr;
    assign work_din   = (state == tok_pkg::G_TERM) ? tok_pkg::CHAR_NUL : text_data;
    assign busy       = (state != tok_pkg::G_IDLE);
    assign group_done = (state == tok_pkg::G_DONE);

    // ------------------------------------------------------------
    // Copy FSM, two cycles per text character.
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= tok_pkg::G_IDLE;
            text_addr  <= '0;
            wr_ptr     <= '0;
            prev_space <= 1'b0;
            wrote_any  <= 1'b0;
        end else begin
            case (state)
                tok_pkg::G_IDLE: begin
                    if (start) begin
                        text_addr  <= '0;
                        wr_ptr     <= '0;
                        prev_space <= 1'b0;
                        wrote_any  <= 1'b0;
                        state      <= tok_pkg::G_READ;
                    end
                end
                // Address is on the RAM, data arrives next cycle.
                tok_pkg::G_READ: begin
                    state <= tok_pkg::G_COPY;
                end
                tok_pkg::G_COPY: begin
                    if (copy) begin
                        wr_ptr     <= wr_ptr + 1'b1;
                        prev_space <= is_space;
                        wrote_any  <= 1'b1;
                    end
                    if (is_end) begin
                        state <= tok_pkg::G_TERM;
                    end else begin
                        text_addr <= text_addr + 1'b1;
                        state     <= tok_pkg::G_READ;
                    end
                end
                tok_pkg::G_TERM: begin
                    state <= tok_pkg::G_DONE;
                end
                tok_pkg::G_DONE: begin
                    state <= tok_pkg::G_IDLE;
                end
                default: begin
                    state <= tok_pkg::G_IDLE;
                end
            endcase
        end
    end

    // The work pointer can never overtake the text it was copied from.
    a_work_behind_text: assert property (
        @(posedge clk) disable iff (!rst_n)
        work_we |-> (work_addr <= text_addr)
    );

endmodule

// ==== rtl/tok_sram.sv ====
`timescale 1ns/1ps

module tok_sram #(
    parameter type word_t = tok_pkg::char_t
) (
    input  logic           clk,
    input  logic           we,
    input  tok_pkg::addr_t addr,
    input  word_t          din,
    output word_t          dout
);

    localparam int DEPTH = 2 ** $bits(tok_pkg::addr_t);

    word_t mem [DEPTH];

    // ------------------------------------------------------------
    // Single port, registered read.
    // ------------------------------------------------------------

    // Write-first, a write returns the new word on dout.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
            dout      <= din;
        end else begin
            dout <= mem[addr];
        end
    end

endmodule

// ==== rtl/tok_pkg.sv ====
`include "tok_defines.svh"

package tok_pkg;

    typedef logic [7:0]             char_t;
    typedef logic [`CODE_WIDTH-1:0] code_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Terminator and slot pad.
    localparam char_t CHAR_NUL   = 8'd0;
    localparam char_t CHAR_SPACE = 8'd32;

    typedef enum logic [2:0] {
        G_IDLE,
        G_READ,
        G_COPY,
        G_TERM,
        G_DONE
    } grp_state_t;

    typedef enum logic [2:0] {
        E_IDLE,
        E_WAIT,
        E_FETCH,
        E_CMP,
        E_NEXT,
        E_EMIT,
        E_ADV,
        E_DONE
    } enc_state_t;

endpackage

// ==== rtl/tok_defines.svh ====
`ifndef TOK_DEFINES_SVH
`define TOK_DEFINES_SVH

// Every RAM in the tokenizer has 2**ADDR_WIDTH words.
`define ADDR_WIDTH 6

// Characters per vocabulary slot, padded with zeros.
`define TOKEN_LEN 4

// Vocabulary entries. The vocabulary RAM holds NUM_ENTRIES * TOKEN_LEN chars.
`define NUM_ENTRIES 16

// Bits per token code.
`define CODE_WIDTH 8

// Code written when no vocabulary entry matches.
`define UNK_CODE {`CODE_WIDTH{1'b1}}

`endif
